// File: bench/l15_bridge_props.svh
`ifndef L15_BRIDGE_PROPS_SVH
`define L15_BRIDGE_PROPS_SVH

  // First cycle out of reset
  assert property (@(posedge clk_i) $fell(rst_i)
    |-> (!transducer_l15_val_o && icache_req_ready_o && dcache_req_ready_o))
    else abort_run($sformatf("At %0t the bridge was not idle right after reset", $time));

  assert property (@(posedge clk_i) disable iff (rst_i) transducer_l15_val_o == exp_val)
    else abort_run($sformatf("Error at %0t: transducer_l15_val_o expected %0b got %0b",
                             $time, $sampled(exp_val), $sampled(transducer_l15_val_o)));

  // Oldest request of the channel that wins arbitration
  assert property (@(posedge clk_i) disable iff (rst_i) exp_val |-> presented == exp_req)
    else abort_run($sformatf("Error at %0t: transducer_l15 request expected %h got %h",
                             $time, $sampled(exp_req), $sampled(presented)));

  assert property (@(posedge clk_i) disable iff (rst_i)
    (transducer_l15_val_o && !l15_transducer_ack_i) |=> presented == $past(presented))
    else abort_run($sformatf("At %0t the request changed while the L1.5 held back ack", $time));

  assert property (@(posedge clk_i) disable iff (rst_i) icache_req_ready_o == exp_icache_ready)
    else abort_run($sformatf("Error at %0t: icache_req_ready_o expected %0b got %0b",
                             $time, $sampled(exp_icache_ready), $sampled(icache_req_ready_o)));

  assert property (@(posedge clk_i) disable iff (rst_i) dcache_req_ready_o == exp_dcache_ready)
    else abort_run($sformatf("Error at %0t: dcache_req_ready_o expected %0b got %0b",
                             $time, $sampled(exp_dcache_ready), $sampled(dcache_req_ready_o)));

  assert property (@(posedge clk_i) disable iff (rst_i) icache_ret_v_o == exp_icache_ret_v)
    else abort_run($sformatf("Error at %0t: icache_ret_v_o expected %0b got %0b",
                             $time, $sampled(exp_icache_ret_v), $sampled(icache_ret_v_o)));

  assert property (@(posedge clk_i) disable iff (rst_i) dcache_ret_v_o == exp_dcache_ret_v)
    else abort_run($sformatf("Error at %0t: dcache_ret_v_o expected %0b got %0b",
                             $time, $sampled(exp_dcache_ret_v), $sampled(dcache_ret_v_o)));

  assert property (@(posedge clk_i) disable iff (rst_i) transducer_l15_req_ack_o == exp_ret_ack)
    else abort_run($sformatf("Error at %0t: transducer_l15_req_ack_o expected %0b got %0b",
                             $time, $sampled(exp_ret_ack), $sampled(transducer_l15_req_ack_o)));

  assert property (@(posedge clk_i) disable iff (rst_i) ret_payload_out == ret_payload_in)
    else abort_run($sformatf("Error at %0t: ret payload expected %h got %h",
                             $time, $sampled(ret_payload_in), $sampled(ret_payload_out)));

`endif

// File: bench/tb_l15_bridge_top.sv
`timescale 1ns/10ps
`include "l15_bridge_defines.svh"

module tb_l15_bridge_top;

  localparam int stim_cycles_lp    = 600;
  localparam int drain_cycles_lp   = 40;
  // Reset, stimulus and drain with a wide margin
  localparam int timeout_cycles_lp = 2000;
  localparam int req_w_lp          = $bits(l15_msg_pkg::l15_req_s);

  localparam logic [3:0] load_ret_lp   = 4'd0;
  localparam logic [3:0] ifill_ret_lp  = 4'd1;
  localparam logic [3:0] atomic_ret_lp = 4'd3;
  localparam logic [3:0] st_ack_lp     = 4'd4;
  localparam logic [3:0] int_ret_lp    = 4'd7;

  logic clk_i, rst_i;
  logic [`L15_RQTYPE_W-1:0] icache_req_rqtype_i, dcache_req_rqtype_i, transducer_l15_rqtype_o;
  logic icache_req_nc_i, dcache_req_nc_i, transducer_l15_nc_o;
  logic [`L15_SIZE_W-1:0] icache_req_size_i, dcache_req_size_i, transducer_l15_size_o;
  logic [`L15_ADDR_W-1:0] icache_req_address_i, dcache_req_address_i, transducer_l15_address_o;
  logic [`L15_DATA_W-1:0] icache_req_data_i, dcache_req_data_i, transducer_l15_data_o;
  logic [`L15_RPLWAY_W-1:0] icache_req_l1rplway_i, dcache_req_l1rplway_i;
  logic [`L15_RPLWAY_W-1:0] transducer_l15_l1rplway_o;
  logic [`L15_AMO_W-1:0] icache_req_amo_op_i, dcache_req_amo_op_i, transducer_l15_amo_op_o;
  logic icache_req_v_i, dcache_req_v_i, icache_req_ready_o, dcache_req_ready_o;
  logic transducer_l15_val_o, l15_transducer_ack_i;
  logic l15_transducer_val_i;
  logic [`L15_RTNTYPE_W-1:0] l15_transducer_returntype_i, ret_rtntype_o;
  logic [`L15_DATA_W-1:0] l15_transducer_data_0_i, l15_transducer_data_1_i;
  logic [`L15_DATA_W-1:0] l15_transducer_data_2_i, l15_transducer_data_3_i;
  logic [`L15_DATA_W-1:0] ret_data_0_o, ret_data_1_o, ret_data_2_o, ret_data_3_o;
  logic l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i;
  logic l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i;
  logic icache_ret_v_o, dcache_ret_v_o, icache_ret_ready_i, dcache_ret_ready_i;
  logic transducer_l15_req_ack_o;

  l15_msg_pkg::l15_req_s icache_exp_q[$], dcache_exp_q[$];
  l15_msg_pkg::l15_req_s exp_req, presented, icache_req, dcache_req;
  logic exp_val, exp_dcache_grant, exp_icache_ready, exp_dcache_ready;
  logic exp_icache_ret_v, exp_dcache_ret_v, exp_ret_ack;
  logic [`L15_RTNTYPE_W+4*`L15_DATA_W-1:0] ret_payload_in, ret_payload_out;
  logic [31:0] rng;
  int cycle_cnt = 0;

  l15_bridge_top l15_bridge_top_i (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_bits(output logic [127:0] bits);
    for (int i = 0; i < 4; i++)
    begin
      rng = xorshift32(rng);
      bits[i*32 +: 32] = rng;
    end
  endtask

  assign presented = {transducer_l15_rqtype_o, transducer_l15_nc_o, transducer_l15_size_o,
                      transducer_l15_address_o, transducer_l15_data_o,
                      transducer_l15_l1rplway_o, transducer_l15_amo_op_o};
  assign icache_req = {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i,
                       icache_req_address_i, icache_req_data_i, icache_req_l1rplway_i,
                       icache_req_amo_op_i};
  assign dcache_req = {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i,
                       dcache_req_address_i, dcache_req_data_i, dcache_req_l1rplway_i,
                       dcache_req_amo_op_i};

  // Return steering from the return type and invalidate flags
  assign exp_icache_ret_v = l15_transducer_val_i
                          && (l15_transducer_inval_icache_inval_i
                              || l15_transducer_inval_icache_all_way_i
                              || l15_transducer_returntype_i == ifill_ret_lp
                              || l15_transducer_returntype_i == int_ret_lp);
  assign exp_dcache_ret_v = l15_transducer_val_i
                          && (l15_transducer_inval_dcache_inval_i
                              || l15_transducer_inval_dcache_all_way_i
                              || l15_transducer_returntype_i == load_ret_lp
                              || l15_transducer_returntype_i == st_ack_lp
                              || l15_transducer_returntype_i == atomic_ret_lp
                              || l15_transducer_returntype_i == int_ret_lp);
  assign exp_ret_ack = (exp_icache_ret_v || exp_dcache_ret_v)
                     && icache_ret_ready_i && dcache_ret_ready_i;
  assign ret_payload_in = {l15_transducer_returntype_i, l15_transducer_data_0_i,
                           l15_transducer_data_1_i, l15_transducer_data_2_i,
                           l15_transducer_data_3_i};
  assign ret_payload_out = {ret_rtntype_o, ret_data_0_o, ret_data_1_o, ret_data_2_o,
                            ret_data_3_o};

  `include "l15_bridge_props.svh"

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles_lp)
      abort_run("Timeout, the run did not finish within the cycle limit");
  end

  // Per-channel scoreboards and the expected L1.5 port
  always @(posedge clk_i)
  begin : scoreboard
    logic hold;
    logic dcache_next;
    if (rst_i)
    begin
      icache_exp_q.delete();
      dcache_exp_q.delete();
    end
    else
    begin
      if (exp_val && l15_transducer_ack_i)
      begin
        if (exp_dcache_grant)
          dcache_exp_q.delete(0);
        else
          icache_exp_q.delete(0);
      end
      if (icache_req_v_i && exp_icache_ready)
        icache_exp_q.push_back(icache_req);
      if (dcache_req_v_i && exp_dcache_ready)
        dcache_exp_q.push_back(dcache_req);
    end
    // An unacked request keeps its channel
    hold = !rst_i && exp_val && !l15_transducer_ack_i;
    dcache_next = hold ? exp_dcache_grant : (dcache_exp_q.size() != 0);
    exp_val <= (icache_exp_q.size() != 0) || (dcache_exp_q.size() != 0);
    exp_dcache_grant <= dcache_next;
    exp_icache_ready <= icache_exp_q.size() < `L15_REQ_ELS;
    exp_dcache_ready <= dcache_exp_q.size() < `L15_REQ_ELS;
    if (dcache_next)
      exp_req <= dcache_exp_q[0];
    else if (icache_exp_q.size() != 0)
      exp_req <= icache_exp_q[0];
    else
      exp_req <= '0;
  end

  task automatic idle_inputs();
    {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
     icache_req_data_i, icache_req_l1rplway_i, icache_req_amo_op_i} = '0;
    {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
     dcache_req_data_i, dcache_req_l1rplway_i, dcache_req_amo_op_i} = '0;
    {icache_req_v_i, dcache_req_v_i, l15_transducer_ack_i, l15_transducer_val_i} = '0;
    l15_transducer_returntype_i = '0;
    {l15_transducer_data_0_i, l15_transducer_data_1_i} = '0;
    {l15_transducer_data_2_i, l15_transducer_data_3_i} = '0;
    {l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i} = '0;
    {l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i} = '0;
    {icache_ret_ready_i, dcache_ret_ready_i} = '0;
  endtask

  task automatic drive_cycle(input int cyc);
    logic [127:0] bits;
    logic [31:0]  ctl;
    logic         slow;
    rng = xorshift32(rng);
    ctl = rng;
    // Stretches of rare acks fill both queues
    slow = (cyc >= 150 && cyc < 300) || (cyc >= 450 && cyc < 500);
    draw_bits(bits);
    {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
     icache_req_data_i, icache_req_l1rplway_i, icache_req_amo_op_i} = bits[req_w_lp-1:0];
    draw_bits(bits);
    {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
     dcache_req_data_i, dcache_req_l1rplway_i, dcache_req_amo_op_i} = bits[req_w_lp-1:0];
    l15_transducer_ack_i = slow ? (ctl[2:0] == 3'd0) : (ctl[2:0] < 3'd5);
    icache_req_v_i = ctl[3] | ctl[4];
    dcache_req_v_i = ctl[5];
    l15_transducer_val_i = ctl[7] | ctl[8];
    l15_transducer_returntype_i = {ctl[12] & ctl[13], ctl[11:9]};
    l15_transducer_inval_icache_inval_i = ctl[14] & ctl[15];
    l15_transducer_inval_icache_all_way_i = ctl[16] & ctl[17];
    l15_transducer_inval_dcache_inval_i = ctl[18] & ctl[19];
    l15_transducer_inval_dcache_all_way_i = ctl[20] & ctl[21];
    icache_ret_ready_i = ctl[22] | ctl[23];
    dcache_ret_ready_i = ctl[24] | ctl[25];
    draw_bits(bits);
    {l15_transducer_data_0_i, l15_transducer_data_1_i} = bits;
    draw_bits(bits);
    {l15_transducer_data_2_i, l15_transducer_data_3_i} = bits;
  endtask

  initial
  begin
    rng = 32'd1553;
    rst_i = 1'b1;
    idle_inputs();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int c = 0; c < stim_cycles_lp; c++)
    begin
      drive_cycle(c);
      @(negedge clk_i);
    end
    // Drain both queues
    idle_inputs();
    l15_transducer_ack_i = 1'b1;
    repeat (drain_cycles_lp) @(negedge clk_i);
    if (icache_exp_q.size() != 0 || dcache_exp_q.size() != 0)
      abort_run("Requests were still queued after the drain phase");
    else
    begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: include/l15_bridge_defines.svh
`ifndef L15_BRIDGE_DEFINES_SVH
`define L15_BRIDGE_DEFINES_SVH

// L1.5 request port field widths
`define L15_ADDR_W     40
`define L15_DATA_W     64
`define L15_RQTYPE_W   5
`define L15_SIZE_W     3
`define L15_AMO_W      4
`define L15_RPLWAY_W   2

// L1.5 return port
`define L15_RTNTYPE_W  4

// Per-channel request queue depth
`define L15_REQ_ELS    4

`endif

// File: l15_bridge_top.f
+incdir+include
+incdir+bench
verilog/l15_msg_pkg.sv
verilog/pce_chan_pkg.sv
verilog/l15_req_fifo.sv
verilog/l15_req_arbiter.sv
verilog/l15_ret_steer.sv
verilog/l15_bridge_top.sv
bench/tb_l15_bridge_top.sv

// File: run.sh
#!/bin/sh
# Builds and runs the L1.5 bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_l15_bridge_top -f l15_bridge_top.f -o tb_l15_bridge_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_l15_bridge_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0

// File: verilog/l15_bridge_top.sv
`timescale 1ns/10ps
`include "l15_bridge_defines.svh"

module l15_bridge_top
  (input                                clk_i
   , input                              rst_i

   , input  [`L15_RQTYPE_W-1:0]         icache_req_rqtype_i
   , input                              icache_req_nc_i
   , input  [`L15_SIZE_W-1:0]           icache_req_size_i
   , input  [`L15_ADDR_W-1:0]           icache_req_address_i
   , input  [`L15_DATA_W-1:0]           icache_req_data_i
   , input  [`L15_RPLWAY_W-1:0]         icache_req_l1rplway_i
   , input  [`L15_AMO_W-1:0]            icache_req_amo_op_i
   , input                              icache_req_v_i
   , output logic                       icache_req_ready_o

   , input  [`L15_RQTYPE_W-1:0]         dcache_req_rqtype_i
   , input                              dcache_req_nc_i
   , input  [`L15_SIZE_W-1:0]           dcache_req_size_i
   , input  [`L15_ADDR_W-1:0]           dcache_req_address_i
   , input  [`L15_DATA_W-1:0]           dcache_req_data_i
   , input  [`L15_RPLWAY_W-1:0]         dcache_req_l1rplway_i
   , input  [`L15_AMO_W-1:0]            dcache_req_amo_op_i
   , input                              dcache_req_v_i
   , output logic                       dcache_req_ready_o

   , output logic [`L15_RQTYPE_W-1:0]   transducer_l15_rqtype_o
   , output logic                       transducer_l15_nc_o
   , output logic [`L15_SIZE_W-1:0]     transducer_l15_size_o
   , output logic [`L15_ADDR_W-1:0]     transducer_l15_address_o
   , output logic [`L15_DATA_W-1:0]     transducer_l15_data_o
   , output logic [`L15_RPLWAY_W-1:0]   transducer_l15_l1rplway_o
   , output logic [`L15_AMO_W-1:0]      transducer_l15_amo_op_o
   , output logic                       transducer_l15_val_o
   , input                              l15_transducer_ack_i

   , input                              l15_transducer_val_i
   , input  [`L15_RTNTYPE_W-1:0]        l15_transducer_returntype_i
   , input  [`L15_DATA_W-1:0]           l15_transducer_data_0_i
   , input  [`L15_DATA_W-1:0]           l15_transducer_data_1_i
   , input  [`L15_DATA_W-1:0]           l15_transducer_data_2_i
   , input  [`L15_DATA_W-1:0]           l15_transducer_data_3_i
   , input                              l15_transducer_inval_icache_inval_i
   , input                              l15_transducer_inval_icache_all_way_i
   , input                              l15_transducer_inval_dcache_inval_i
   , input                              l15_transducer_inval_dcache_all_way_i

   , output logic                       icache_ret_v_o
   , output logic                       dcache_ret_v_o
   , input                              icache_ret_ready_i
   , input                              dcache_ret_ready_i
   , output logic [`L15_RTNTYPE_W-1:0]  ret_rtntype_o
   , output logic [`L15_DATA_W-1:0]     ret_data_0_o
   , output logic [`L15_DATA_W-1:0]     ret_data_1_o
   , output logic [`L15_DATA_W-1:0]     ret_data_2_o
   , output logic [`L15_DATA_W-1:0]     ret_data_3_o
   , output logic                       transducer_l15_req_ack_o
   );

  l15_msg_pkg::l15_req_s       icache_req_li, dcache_req_li;
  l15_msg_pkg::l15_req_s [1:0] fifo_data_lo;
  pce_chan_pkg::chan_mask_t    fifo_v_lo, fifo_yumi_li, ret_v_lo, ret_ready_li;

  assign icache_req_li = '{rqtype   : icache_req_rqtype_i
                           ,nc      : icache_req_nc_i
                           ,size    : icache_req_size_i
                           ,address : icache_req_address_i
                           ,data    : icache_req_data_i
                           ,l1rplway: icache_req_l1rplway_i
                           ,amo_op  : icache_req_amo_op_i
                           };

  assign dcache_req_li = '{rqtype   : dcache_req_rqtype_i
                           ,nc      : dcache_req_nc_i
                           ,size    : dcache_req_size_i
                           ,address : dcache_req_address_i
                           ,data    : dcache_req_data_i
                           ,l1rplway: dcache_req_l1rplway_i
                           ,amo_op  : dcache_req_amo_op_i
                           };

  l15_req_fifo icache_fifo
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.data_i(icache_req_li)
     ,.v_i(icache_req_v_i)
     ,.ready_o(icache_req_ready_o)
     ,.data_o(fifo_data_lo[pce_chan_pkg::e_icache_chan])
     ,.v_o(fifo_v_lo[pce_chan_pkg::e_icache_chan])
     ,.yumi_i(fifo_yumi_li[pce_chan_pkg::e_icache_chan])
     );

  l15_req_fifo dcache_fifo
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.data_i(dcache_req_li)
     ,.v_i(dcache_req_v_i)
     ,.ready_o(dcache_req_ready_o)
     ,.data_o(fifo_data_lo[pce_chan_pkg::e_dcache_chan])
     ,.v_o(fifo_v_lo[pce_chan_pkg::e_dcache_chan])
     ,.yumi_i(fifo_yumi_li[pce_chan_pkg::e_dcache_chan])
     );

  l15_req_arbiter req_arb
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.heads_i(fifo_data_lo)
     ,.heads_v_i(fifo_v_lo)
     ,.yumi_o(fifo_yumi_li)
     ,.transducer_l15_rqtype_o(transducer_l15_rqtype_o)
     ,.transducer_l15_nc_o(transducer_l15_nc_o)
     ,.transducer_l15_size_o(transducer_l15_size_o)
     ,.transducer_l15_address_o(transducer_l15_address_o)
     ,.transducer_l15_data_o(transducer_l15_data_o)
     ,.transducer_l15_l1rplway_o(transducer_l15_l1rplway_o)
     ,.transducer_l15_amo_op_o(transducer_l15_amo_op_o)
     ,.transducer_l15_val_o(transducer_l15_val_o)
     ,.l15_transducer_ack_i(l15_transducer_ack_i)
     );

  // Return payload goes to both caches unchanged
  assign ret_rtntype_o = l15_transducer_returntype_i;
  assign ret_data_0_o  = l15_transducer_data_0_i;
  assign ret_data_1_o  = l15_transducer_data_1_i;
  assign ret_data_2_o  = l15_transducer_data_2_i;
  assign ret_data_3_o  = l15_transducer_data_3_i;

  assign ret_ready_li[pce_chan_pkg::e_icache_chan] = icache_ret_ready_i;
  assign ret_ready_li[pce_chan_pkg::e_dcache_chan] = dcache_ret_ready_i;
  assign icache_ret_v_o = ret_v_lo[pce_chan_pkg::e_icache_chan];
  assign dcache_ret_v_o = ret_v_lo[pce_chan_pkg::e_dcache_chan];

  l15_ret_steer ret_steer
    (.l15_transducer_val_i(l15_transducer_val_i)
     ,.l15_transducer_returntype_i(l15_msg_pkg::l15_rtntype_e'(l15_transducer_returntype_i))
     ,.l15_transducer_inval_icache_inval_i(l15_transducer_inval_icache_inval_i)
     ,.l15_transducer_inval_icache_all_way_i(l15_transducer_inval_icache_all_way_i)
     ,.l15_transducer_inval_dcache_inval_i(l15_transducer_inval_dcache_inval_i)
     ,.l15_transducer_inval_dcache_all_way_i(l15_transducer_inval_dcache_all_way_i)
     ,.ret_ready_i(ret_ready_li)
     ,.ret_v_o(ret_v_lo)
     ,.transducer_l15_req_ack_o(transducer_l15_req_ack_o)
     );

endmodule

// File: verilog/l15_msg_pkg.sv
`include "l15_bridge_defines.svh"

package l15_msg_pkg;

  // Return types seen on the L1.5 return port
  typedef enum logic [`L15_RTNTYPE_W-1:0]
  {
    e_load_ret   = 0,
    e_ifill_ret  = 1,
    e_atomic_ret = 3,
    e_st_ack     = 4,
    e_int_ret    = 7
  } l15_rtntype_e;

  // One request as presented to the L1.5
  typedef struct packed
  {
    logic [`L15_RQTYPE_W-1:0] rqtype;
    logic                     nc;
    logic [`L15_SIZE_W-1:0]   size;
    logic [`L15_ADDR_W-1:0]   address;
    logic [`L15_DATA_W-1:0]   data;
    logic [`L15_RPLWAY_W-1:0] l1rplway;
    logic [`L15_AMO_W-1:0]    amo_op;
  } l15_req_s;

endpackage

// File: verilog/l15_req_arbiter.sv
`timescale 1ns/10ps
`include "l15_bridge_defines.svh"

module l15_req_arbiter
  (input                                 clk_i
   , input                               rst_i

   , input  l15_msg_pkg::l15_req_s [1:0] heads_i
   , input  pce_chan_pkg::chan_mask_t    heads_v_i
   , output pce_chan_pkg::chan_mask_t    yumi_o

   , output logic [`L15_RQTYPE_W-1:0]    transducer_l15_rqtype_o
   , output logic                        transducer_l15_nc_o
   , output logic [`L15_SIZE_W-1:0]      transducer_l15_size_o
   , output logic [`L15_ADDR_W-1:0]      transducer_l15_address_o
   , output logic [`L15_DATA_W-1:0]      transducer_l15_data_o
   , output logic [`L15_RPLWAY_W-1:0]    transducer_l15_l1rplway_o
   , output logic [`L15_AMO_W-1:0]       transducer_l15_amo_op_o
   , output logic                        transducer_l15_val_o
   , input                               l15_transducer_ack_i
   );

  pce_chan_pkg::chan_mask_t fresh_grant, grant, lock_grant_r;
  l15_msg_pkg::l15_req_s    sel_req;
  logic                     lock_r;

  // Data cache first
  assign fresh_grant[pce_chan_pkg::e_dcache_chan] = heads_v_i[pce_chan_pkg::e_dcache_chan];
  assign fresh_grant[pce_chan_pkg::e_icache_chan] = heads_v_i[pce_chan_pkg::e_icache_chan]
                                                  & ~heads_v_i[pce_chan_pkg::e_dcache_chan];

  // A request waiting for ack keeps its grant
  assign grant = lock_r ? lock_grant_r : fresh_grant;

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        lock_r <= 1'b0;
      else
        lock_r <= transducer_l15_val_o & ~l15_transducer_ack_i;
    end

  always_ff @(posedge clk_i)
    begin
      lock_grant_r <= grant;
    end

  always_comb
    begin
      if (grant[pce_chan_pkg::e_dcache_chan])
        sel_req = heads_i[pce_chan_pkg::e_dcache_chan];
      else
        sel_req = heads_i[pce_chan_pkg::e_icache_chan];
    end

  assign transducer_l15_rqtype_o   = sel_req.rqtype;
  assign transducer_l15_nc_o       = sel_req.nc;
  assign transducer_l15_size_o     = sel_req.size;
  assign transducer_l15_address_o  = sel_req.address;
  assign transducer_l15_data_o     = sel_req.data;
  assign transducer_l15_l1rplway_o = sel_req.l1rplway;
  assign transducer_l15_amo_op_o   = sel_req.amo_op;
  assign transducer_l15_val_o      = |grant;

  assign yumi_o = grant & {2{l15_transducer_ack_i}};

  // At most one grant, and only to a queue that has a head
  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant) && ((grant & ~heads_v_i) == '0));

  // L1.5 sees the same request until it acks
  assert property (@(posedge clk_i) disable iff (rst_i)
    (transducer_l15_val_o && !l15_transducer_ack_i)
      |=> (transducer_l15_val_o && $stable(sel_req) && $stable(grant)));

endmodule

// File: verilog/l15_req_fifo.sv
`timescale 1ns/10ps
`include "l15_bridge_defines.svh"

module l15_req_fifo
  #(parameter int els_p = `L15_REQ_ELS
    )
  (input                           clk_i
   , input                         rst_i

   , input  l15_msg_pkg::l15_req_s data_i
   , input                         v_i
   , output logic                  ready_o

   , output l15_msg_pkg::l15_req_s data_o
   , output logic                  v_o
   , input                         yumi_i
   );

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  l15_msg_pkg::l15_req_s mem_r [els_p];

  logic [ptr_w_lp-1:0] rptr_r, wptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                enq, deq;

  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i;
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i)
    begin
      if (enq)
        mem_r[wptr_r] <= data_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          rptr_r  <= '0;
          wptr_r  <= '0;
          count_r <= '0;
        end
      else
        begin
          if (enq)
            wptr_r <= (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
          if (deq)
            rptr_r <= (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;

          case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
          endcase
        end
    end

  // Consumer may only take a head that is there
  assert property (@(posedge clk_i) disable iff (rst_i)
    yumi_i |-> v_o);

  // When full the next write slot is the head itself
  assert property (@(posedge clk_i) disable iff (rst_i)
    !ready_o |-> (wptr_r == rptr_r));

endmodule

// File: verilog/l15_ret_steer.sv
`timescale 1ns/10ps

module l15_ret_steer
  (input                                l15_transducer_val_i
   , input l15_msg_pkg::l15_rtntype_e   l15_transducer_returntype_i
   , input                              l15_transducer_inval_icache_inval_i
   , input                              l15_transducer_inval_icache_all_way_i
   , input                              l15_transducer_inval_dcache_inval_i
   , input                              l15_transducer_inval_dcache_all_way_i

   , input  pce_chan_pkg::chan_mask_t   ret_ready_i
   , output pce_chan_pkg::chan_mask_t   ret_v_o
   , output logic                       transducer_l15_req_ack_o
   );

  logic icache_want, dcache_want;

  assign icache_want = l15_transducer_inval_icache_inval_i
                     | l15_transducer_inval_icache_all_way_i
                     | (l15_transducer_returntype_i inside
                         {l15_msg_pkg::e_int_ret, l15_msg_pkg::e_ifill_ret});

  assign dcache_want = l15_transducer_inval_dcache_inval_i
                     | l15_transducer_inval_dcache_all_way_i
                     | (l15_transducer_returntype_i inside
                         {l15_msg_pkg::e_int_ret, l15_msg_pkg::e_load_ret,
                          l15_msg_pkg::e_st_ack, l15_msg_pkg::e_atomic_ret});

  assign ret_v_o[pce_chan_pkg::e_icache_chan] = l15_transducer_val_i & icache_want;
  assign ret_v_o[pce_chan_pkg::e_dcache_chan] = l15_transducer_val_i & dcache_want;

  // Invalidates can target both caches, so wait on both
  assign transducer_l15_req_ack_o = (|ret_v_o) & (&ret_ready_i);

endmodule

// File: verilog/pce_chan_pkg.sv
package pce_chan_pkg;

  localparam int num_chans_gp = 2;

  // Channel index, also the bit position in a channel mask
  typedef enum logic
  {
    e_icache_chan = 1'b0,
    e_dcache_chan = 1'b1
  } pce_chan_e;

  typedef logic [num_chans_gp-1:0] chan_mask_t;

endpackage
